/* hw/clint_cfg_pkg.sv */
package clint_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  localparam int num_harts_lp      = 4;
  localparam int hart_idx_width_lp = 2;
  localparam int dword_width_lp    = 64;
  localparam int apb_addr_width_lp = 12;
  localparam int apb_data_width_lp = 32;

  // address space per hart.
  localparam int hart_stride_lp        = 32;
  localparam int reg_offset_width_lp   = $clog2(hart_stride_lp); // hart index starts at bit 5.
  localparam int hart_field_width_lp   = apb_addr_width_lp - reg_offset_width_lp;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // offsets within one hart block
  localparam logic [reg_offset_width_lp-1:0] msip_offset_lp        = 5'h00;
  localparam logic [reg_offset_width_lp-1:0] mtimecmp_lo_offset_lp = 5'h08;
  localparam logic [reg_offset_width_lp-1:0] mtimecmp_hi_offset_lp = 5'h0C;
  localparam logic [reg_offset_width_lp-1:0] mtime_lo_offset_lp    = 5'h10;
  localparam logic [reg_offset_width_lp-1:0] mtime_hi_offset_lp    = 5'h14;
  localparam logic [reg_offset_width_lp-1:0] meip_offset_lp        = 5'h18;

  // clock cycles per mtime tick.
  localparam int rtc_ratio_lp       = 8;
  localparam int rtc_cnt_width_lp   = $clog2(rtc_ratio_lp);

  typedef enum logic [1:0] {
    reg_msip, reg_mtimecmp, reg_mtime, reg_meip
  } clint_reg_e;

endpackage

/* hw/clint_bus_pkg.sv */
package clint_bus_pkg;

  import clint_cfg_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // apb slave port
  typedef struct packed {
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [apb_addr_width_lp-1:0] paddr;
    logic [apb_data_width_lp-1:0] pwdata;
  } apb_req_s;

  typedef struct packed {
    logic [apb_data_width_lp-1:0] prdata;
    logic                         pready;
    logic                         pslverr;
  } apb_resp_s;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoder to slices, broadcast to all harts
  typedef struct packed {
    logic                         wr_v;    // first access cycle of a legal write.
    logic [hart_idx_width_lp-1:0] hart;
    clint_reg_e                   reg_sel;
    logic                         hi;      // upper 32 bits of a 64-bit register.
    logic [apb_data_width_lp-1:0] wdata;
  } slice_req_s;

  // slice back to collector.
  typedef struct packed {
    logic [dword_width_lp-1:0] rdata;
    logic                      software_irq;
    logic                      timer_irq;
    logic                      external_irq;
  } slice_resp_s;

endpackage

/* hw/clint_apb_decode.sv */
`timescale 1ns/1ps

module clint_apb_decode
  import clint_cfg_pkg::*;
  import clint_bus_pkg::*;
  (input  logic       clk_i
   , input  logic       reset_i
   , input  apb_req_s   apb_req_i

   , output slice_req_s slice_req_o
   , output logic       addr_err_o
   , output logic       access_first_o
   , output logic       pready_o
   );

  typedef enum logic {acc_first_s, acc_wait_s} acc_state_e;

  acc_state_e                       state_r;
  logic                             in_access;
  logic [hart_field_width_lp-1:0]   hart_field;
  logic [reg_offset_width_lp-1:0]   offset;
  logic                             hart_err;
  logic                             offset_err;
  clint_reg_e                       reg_sel;
  logic                             hi;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address split
  assign hart_field = apb_req_i.paddr[apb_addr_width_lp-1:reg_offset_width_lp];
  assign offset     = apb_req_i.paddr[reg_offset_width_lp-1:0];
  assign hart_err   = (hart_field >= num_harts_lp); // covers harts 4 through 127.

  always_comb begin
    reg_sel    = reg_msip;
    hi         = 1'b0;
    offset_err = 1'b0;
    case (offset)
      msip_offset_lp:        reg_sel = reg_msip;
      mtimecmp_lo_offset_lp: reg_sel = reg_mtimecmp;
      mtimecmp_hi_offset_lp: begin
        reg_sel = reg_mtimecmp;
        hi      = 1'b1;
      end
      mtime_lo_offset_lp:    reg_sel = reg_mtime;
      mtime_hi_offset_lp: begin
        reg_sel = reg_mtime;
        hi      = 1'b1;
      end
      meip_offset_lp:        reg_sel = reg_meip;
      default:               offset_err = 1'b1; // hole in the map.
    endcase
  end

  assign addr_err_o = hart_err | offset_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access tracker, one fixed wait state
  assign in_access = apb_req_i.psel & apb_req_i.penable;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= acc_first_s;
    end else if (state_r == acc_wait_s) begin
      state_r <= acc_first_s; // transfer completes this cycle.
    end else if (in_access) begin
      state_r <= acc_wait_s;
    end
  end

  assign access_first_o = in_access & (state_r == acc_first_s);
  assign pready_o       = in_access & (state_r == acc_wait_s);

  assign slice_req_o.wr_v    = access_first_o & apb_req_i.pwrite & ~addr_err_o;
  assign slice_req_o.hart    = apb_req_i.paddr[reg_offset_width_lp +: hart_idx_width_lp];
  assign slice_req_o.reg_sel = reg_sel;
  assign slice_req_o.hi      = hi;
  assign slice_req_o.wdata   = apb_req_i.pwdata;

  // master must hold the request until pready.
  apb_req_stable_a : assert property (@(posedge clk_i) disable iff (reset_i)
    (in_access && !pready_o) |=> $stable(apb_req_i))
    else $error("apb request changed during wait state.");

endmodule

/* hw/clint_rtc_strobe.sv */
`timescale 1ns/1ps

module clint_rtc_strobe
  import clint_cfg_pkg::*;
  (input  logic clk_i
   , input  logic reset_i
   , output logic strobe_o
   );

  localparam logic [rtc_cnt_width_lp-1:0] reload_lp = rtc_cnt_width_lp'(rtc_ratio_lp - 1);

  logic [rtc_cnt_width_lp-1:0] cnt_r;
  logic                        strobe_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r    <= reload_lp;
      strobe_r <= 1'b0;
    end else begin
      strobe_r <= (cnt_r == '0); // lands rtc_ratio_lp cycles after reset.
      if (cnt_r == '0)
        cnt_r <= reload_lp;
      else
        cnt_r <= cnt_r - 1'b1;
    end
  end

  assign strobe_o = strobe_r;

  strobe_single_a : assert property (@(posedge clk_i) disable iff (reset_i)
    strobe_r |=> !strobe_r)
    else $error("rtc strobe held for more than one cycle.");

endmodule

/* hw/clint_slice.sv */
`timescale 1ns/1ps

module clint_slice
  import clint_cfg_pkg::*;
  import clint_bus_pkg::*;
  (input  logic                         clk_i
   , input  logic                         reset_i
   , input  logic [hart_idx_width_lp-1:0] hart_id_i
   , input  slice_req_s                   slice_req_i
   , input  logic                         strobe_i

   , output slice_resp_s                  slice_resp_o
   );

  logic [dword_width_lp-1:0] mtime_r;
  logic [dword_width_lp-1:0] mtimecmp_r;
  logic                      msip_r;
  logic                      meip_r;

  logic wr_hit;
  logic mtime_wr;
  logic mtimecmp_wr;
  logic msip_wr;
  logic meip_wr;
  logic timer_irq;

  // replace one 32-bit half of a 64-bit register.
  function automatic logic [dword_width_lp-1:0] merge_half(
    input logic [dword_width_lp-1:0]    cur,
    input logic                         upper,
    input logic [apb_data_width_lp-1:0] wdata
  );
    logic [dword_width_lp-1:0] res;
    res = cur;
    if (upper)
      res[dword_width_lp-1:apb_data_width_lp] = wdata;
    else
      res[apb_data_width_lp-1:0] = wdata;
    return res;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write decode
  assign wr_hit      = slice_req_i.wr_v && (slice_req_i.hart == hart_id_i);
  assign mtime_wr    = wr_hit && (slice_req_i.reg_sel == reg_mtime);
  assign mtimecmp_wr = wr_hit && (slice_req_i.reg_sel == reg_mtimecmp);
  assign msip_wr     = wr_hit && (slice_req_i.reg_sel == reg_msip);
  assign meip_wr     = wr_hit && (slice_req_i.reg_sel == reg_meip);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_r <= '0;
    end else if (mtime_wr) begin
      mtime_r <= merge_half(mtime_r, slice_req_i.hi, slice_req_i.wdata); // write beats tick.
    end else if (strobe_i) begin
      mtime_r <= mtime_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtimecmp_r <= '1; // parked out of reach.
      msip_r     <= 1'b0;
      meip_r     <= 1'b0;
    end else begin
      if (mtimecmp_wr)
        mtimecmp_r <= merge_half(mtimecmp_r, slice_req_i.hi, slice_req_i.wdata);
      if (msip_wr)
        msip_r <= slice_req_i.wdata[0];
      if (meip_wr)
        meip_r <= slice_req_i.wdata[0];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read mux and interrupts
  assign timer_irq = (mtime_r >= mtimecmp_r);

  always_comb begin
    case (slice_req_i.reg_sel)
      reg_msip:     slice_resp_o.rdata = dword_width_lp'(msip_r);
      reg_mtimecmp: slice_resp_o.rdata = mtimecmp_r;
      reg_mtime:    slice_resp_o.rdata = mtime_r;
      default:      slice_resp_o.rdata = dword_width_lp'(meip_r);
    endcase
  end

  assign slice_resp_o.software_irq = msip_r;
  assign slice_resp_o.timer_irq    = timer_irq;
  assign slice_resp_o.external_irq = meip_r;

  // holds or steps by one unless software wrote it.
  mtime_monotonic_a : assert property (@(posedge clk_i) disable iff (reset_i)
    !mtime_wr |=> (mtime_r == $past(mtime_r)) || (mtime_r == $past(mtime_r) + 1'b1))
    else $error("mtime moved without a strobe or write.");

  // timer can only fire after a tick or a register write.
  timer_irq_cause_a : assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(timer_irq) |-> $past(strobe_i || mtime_wr || mtimecmp_wr))
    else $error("timer_irq rose without a cause.");

endmodule

/* hw/clint_resp_collect.sv */
`timescale 1ns/1ps

module clint_resp_collect
  import clint_cfg_pkg::*;
  import clint_bus_pkg::*;
  (input  logic                                 clk_i
   , input  logic                                 reset_i
   , input  slice_resp_s [num_harts_lp-1:0]       slice_resp_i
   , input  slice_req_s                           slice_req_i
   , input  logic                                 access_first_i
   , input  logic                                 addr_err_i
   , input  logic                                 pready_i

   , output apb_resp_s                            apb_resp_o
   , output logic [num_harts_lp-1:0]              software_irq_o
   , output logic [num_harts_lp-1:0]              timer_irq_o
   , output logic [num_harts_lp-1:0]              external_irq_o
   );

  slice_resp_s                  sel_resp;
  logic [apb_data_width_lp-1:0] sel_half;
  logic [apb_data_width_lp-1:0] rdata_r;
  logic                         err_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read capture
  assign sel_resp = slice_resp_i[slice_req_i.hart];
  assign sel_half = slice_req_i.hi ? sel_resp.rdata[dword_width_lp-1:apb_data_width_lp]
                                   : sel_resp.rdata[apb_data_width_lp-1:0];

  always_ff @(posedge clk_i) begin
    if (access_first_i)
      rdata_r <= addr_err_i ? '0 : sel_half; // errors read as zero.
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      err_r <= 1'b0;
    else if (access_first_i)
      err_r <= addr_err_i;
  end

  assign apb_resp_o.prdata  = rdata_r;
  assign apb_resp_o.pready  = pready_i;
  assign apb_resp_o.pslverr = pready_i & err_r;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // interrupt fan-out
  always_comb begin
    for (int h = 0; h < num_harts_lp; h++) begin
      software_irq_o[h] = slice_resp_i[h].software_irq;
      timer_irq_o[h]    = slice_resp_i[h].timer_irq;
      external_irq_o[h] = slice_resp_i[h].external_irq;
    end
  end

endmodule

/* hw/clint_top.sv */
`timescale 1ns/1ps

module clint_top
  import clint_cfg_pkg::*;
  import clint_bus_pkg::*;
  (input  logic                    clk_i
   , input  logic                    reset_i
   , input  apb_req_s                apb_req_i

   , output apb_resp_s               apb_resp_o
   , output logic [num_harts_lp-1:0] software_irq_o
   , output logic [num_harts_lp-1:0] timer_irq_o
   , output logic [num_harts_lp-1:0] external_irq_o
   );

  slice_req_s                    slice_req;
  slice_resp_s [num_harts_lp-1:0] slice_resp;
  logic                          addr_err;
  logic                          access_first;
  logic                          pready;
  logic                          mtime_strobe;

  clint_apb_decode decode
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.apb_req_i(apb_req_i)
     ,.slice_req_o(slice_req)
     ,.addr_err_o(addr_err)
     ,.access_first_o(access_first)
     ,.pready_o(pready)
     );

  clint_rtc_strobe rtc_strobe
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.strobe_o(mtime_strobe)
     );

  // one slice per hart, told apart by hart_id_i.
  for (genvar i = 0; i < num_harts_lp; i++) begin : g_slice
    clint_slice slice
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.hart_id_i(hart_idx_width_lp'(i))
       ,.slice_req_i(slice_req)
       ,.strobe_i(mtime_strobe)
       ,.slice_resp_o(slice_resp[i])
       );
  end

  clint_resp_collect collect
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.slice_resp_i(slice_resp)
     ,.slice_req_i(slice_req)
     ,.access_first_i(access_first)
     ,.addr_err_i(addr_err)
     ,.pready_i(pready)
     ,.apb_resp_o(apb_resp_o)
     ,.software_irq_o(software_irq_o)
     ,.timer_irq_o(timer_irq_o)
     ,.external_irq_o(external_irq_o)
     );

endmodule

/* verif/clint_tb.sv */
`timescale 1ns/1ps

module clint_tb
  import clint_cfg_pkg::*;
  import clint_bus_pkg::*;
  ();

  localparam int clk_period_lp   = 40;
  localparam int rand_iters_lp   = 200;
  localparam int err_iters_lp    = 8;
  localparam int max_polls_lp    = 24;
  localparam int reset_txns_lp   = 3 * num_harts_lp;
  localparam int rand_txns_lp    = 2 * rand_iters_lp;
  localparam int mtime_txns_lp   = 2 * num_harts_lp + 2;
  localparam int timer_txns_lp   = max_polls_lp + 4;
  localparam int err_txns_lp     = 4 * err_iters_lp + 6 * num_harts_lp;
  localparam int total_txns_lp   = reset_txns_lp + rand_txns_lp + mtime_txns_lp
                                   + timer_txns_lp + err_txns_lp;
  localparam int watchdog_cyc_lp = total_txns_lp * 4 * 3 / 2;

  logic                    clk_i;
  logic                    reset_i;
  apb_req_s                apb_req;
  apb_resp_s               apb_resp;
  logic [num_harts_lp-1:0] software_irq;
  logic [num_harts_lp-1:0] timer_irq;
  logic [num_harts_lp-1:0] external_irq;

  // register model.
  logic            msip_m       [num_harts_lp];
  logic            meip_m       [num_harts_lp];
  logic [63:0]     cmp_m        [num_harts_lp];
  logic [63:0]     mtime_base_m [num_harts_lp];
  longint unsigned mtime_cyc_m  [num_harts_lp]; // cycle of the last mtime low write.

  logic [4:0] plain_offs [4] = '{5'h00, 5'h08, 5'h0C, 5'h18};
  logic [4:0] all_offs   [6] = '{5'h00, 5'h08, 5'h0C, 5'h10, 5'h14, 5'h18};

  longint unsigned cycle_cnt = 0;
  int              err_cnt = 0;
  int              tests_passed = 0;
  int              tests_failed = 0;
  bit              busy = 1'b0;
  bit              monitor_on = 1'b0;

  clint_top dut
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.apb_req_i(apb_req)
     ,.apb_resp_o(apb_resp)
     ,.software_irq_o(software_irq)
     ,.timer_irq_o(timer_irq)
     ,.external_irq_o(external_irq)
     );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("mismatch %s expected 0x%0h got 0x%0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok) else begin
      $display("error: %s", what);
      err_cnt++;
    end
  endtask

  function automatic bit is_mapped(input logic [4:0] off);
    return off inside {5'h00, 5'h08, 5'h0C, 5'h10, 5'h14, 5'h18};
  endfunction

  function automatic logic [31:0] model_value(input int hart, input logic [4:0] off);
    case (off)
      5'h00:   return 32'(msip_m[hart]);
      5'h08:   return cmp_m[hart][31:0];
      5'h0C:   return cmp_m[hart][63:32];
      5'h18:   return 32'(meip_m[hart]);
      default: return '0;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // apb driver
  task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    int cycles;
    @(posedge clk_i);
    #2;
    apb_req.psel    = 1'b1; // setup.
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk_i);
    #2;
    busy = 1'b1; // a write lands before the model sees it.
    apb_req.penable = 1'b1;
    cycles = 1;
    @(negedge clk_i);
    while (!apb_resp.pready && cycles < 6) begin
      @(negedge clk_i);
      cycles++;
    end
    check_true(apb_resp.pready && cycles == 2,
               $sformatf("pready not high two cycles after setup at 0x%03h", addr));
    rdata = apb_resp.prdata;
    err   = apb_resp.pslverr;
    @(posedge clk_i);
    #2;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    busy = 1'b0;
  endtask

  task automatic reg_write(input int hart, input logic [4:0] off, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    bit          bad;
    bad = (hart >= num_harts_lp) || !is_mapped(off);
    apb_transfer(1'b1, 12'(hart * hart_stride_lp) | 12'(off), data, unused, err);
    check_equal("pslverr", 64'(bad), 64'(err));
    if (!bad) begin
      case (off)
        5'h00: msip_m[hart] = data[0];
        5'h08: cmp_m[hart][31:0] = data;
        5'h0C: cmp_m[hart][63:32] = data;
        5'h10: begin
          mtime_base_m[hart][31:0] = data;
          mtime_cyc_m[hart] = cycle_cnt;
        end
        5'h14: mtime_base_m[hart][63:32] = data;
        default: meip_m[hart] = data[0];
      endcase
    end
  endtask

  task automatic reg_read(input int hart, input logic [4:0] off, output logic [31:0] data);
    logic err;
    bit   bad;
    bad = (hart >= num_harts_lp) || !is_mapped(off);
    apb_transfer(1'b0, 12'(hart * hart_stride_lp) | 12'(off), '0, data, err);
    check_equal("pslverr", 64'(bad), 64'(err));
  endtask

  // mtime can only be bounded, it keeps counting between write and read.
  task automatic reg_read_check(input int hart, input logic [4:0] off);
    logic [31:0] val;
    logic [31:0] lo_min;
    logic [63:0] lo_max;
    reg_read(hart, off, val);
    if (off == 5'h14) begin
      check_equal($sformatf("mtime_hi[%0d]", hart), 64'(mtime_base_m[hart][63:32]), 64'(val));
    end else if (off == 5'h10) begin
      lo_min = mtime_base_m[hart][31:0];
      lo_max = 64'(lo_min) + (cycle_cnt - mtime_cyc_m[hart]) / rtc_ratio_lp + 1;
      assert (val >= lo_min && 64'(val) <= lo_max) else begin
        $display("mismatch mtime_lo[%0d] expected 0x%0h..0x%0h got 0x%0h",
                 hart, lo_min, lo_max, val);
        err_cnt++;
      end
    end else begin
      check_equal($sformatf("prdata[%0d] at 0x%02h", hart, off),
                  64'(model_value(hart, off)), 64'(val));
    end
  endtask

  // software and external lines must follow the model outside the access phase.
  always @(negedge clk_i) begin : irq_monitor
    logic [num_harts_lp-1:0] sw_exp;
    logic [num_harts_lp-1:0] ext_exp;
    for (int h = 0; h < num_harts_lp; h++) begin
      sw_exp[h]  = msip_m[h];
      ext_exp[h] = meip_m[h];
    end
    if (monitor_on && !busy) begin
      check_equal("software_irq_o", 64'(sw_exp), 64'(software_irq));
      check_equal("external_irq_o", 64'(ext_exp), 64'(external_irq));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  task automatic test_reset();
    check_equal("timer_irq_o", 0, 64'(timer_irq));
    check_equal("software_irq_o", 0, 64'(software_irq));
    check_equal("external_irq_o", 0, 64'(external_irq));
    for (int h = 0; h < num_harts_lp; h++) begin
      reg_read_check(h, 5'h08);
      reg_read_check(h, 5'h0C);
      reg_read_check(h, 5'h00);
    end
  endtask

  task automatic test_random();
    for (int i = 0; i < rand_iters_lp; i++) begin
      reg_write($urandom % num_harts_lp, plain_offs[$urandom % 4], $urandom);
      reg_read_check($urandom % num_harts_lp, all_offs[$urandom % 6]);
    end
  endtask

  task automatic test_mtime();
    int h;
    h = $urandom % num_harts_lp;
    reg_write(h, 5'h10, $urandom & 32'h7fff_ffff); // no carry into the high word.
    reg_write(h, 5'h14, $urandom & 32'h7fff_ffff);
    for (int o = 0; o < num_harts_lp; o++) begin
      reg_read_check(o, 5'h10);
      reg_read_check(o, 5'h14);
    end
  endtask

  task automatic test_timer();
    int          h;
    bit          reached;
    logic [31:0] now;
    logic [31:0] cmp_lo;
    h = $urandom % num_harts_lp;
    reached = 1'b0;
    reg_read(h, 5'h10, now);
    cmp_lo = now + 4 + ($urandom % 4);
    reg_write(h, 5'h0C, mtime_base_m[h][63:32]);
    reg_write(h, 5'h08, cmp_lo);
    for (int i = 0; i < max_polls_lp && !reached; i++) begin
      reg_read(h, 5'h10, now);
      if (now >= cmp_lo) begin
        check_true(timer_irq[h], "timer_irq low although mtime reached mtimecmp");
        reached = 1'b1;
      end else if (33'(now) + 1 < 33'(cmp_lo)) begin
        check_equal("timer_irq_o", 0, 64'(timer_irq[h])); // at most one tick since the read.
      end
    end
    check_true(reached, "mtime never reached mtimecmp");
    reg_write(h, 5'h0C, 32'hffff_ffff);
    check_equal("timer_irq_o", 0, 64'(timer_irq[h]));
  endtask

  task automatic test_errors();
    logic [31:0] unused;
    logic [4:0]  off;
    for (int i = 0; i < err_iters_lp; i++) begin
      reg_write(num_harts_lp + $urandom % 4, all_offs[$urandom % 6], $urandom);
      reg_read(num_harts_lp + $urandom % 4, all_offs[$urandom % 6], unused);
      do off = 5'($urandom); while (is_mapped(off));
      reg_write($urandom % num_harts_lp, off, $urandom);
      reg_read($urandom % num_harts_lp, off, unused);
    end
    for (int h = 0; h < num_harts_lp; h++) begin
      for (int k = 0; k < 6; k++) reg_read_check(h, all_offs[k]);
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
      tests_failed++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  initial begin
    int errs;
    void'($urandom(32'h00134768));
    reset_i = 1'b1;
    apb_req = '0;
    for (int h = 0; h < num_harts_lp; h++) begin
      msip_m[h]       = 1'b0;
      meip_m[h]       = 1'b0;
      cmp_m[h]        = '1;
      mtime_base_m[h] = '0;
    end
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int h = 0; h < num_harts_lp; h++) mtime_cyc_m[h] = cycle_cnt;
    monitor_on = 1'b1;

    errs = err_cnt;
    test_reset();
    close_test("reset values", errs);
    errs = err_cnt;
    test_random();
    close_test("random read-back", errs);
    errs = err_cnt;
    test_mtime();
    close_test("mtime", errs);
    errs = err_cnt;
    test_timer();
    close_test("timer interrupt", errs);
    errs = err_cnt;
    test_errors();
    close_test("errors", errs);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial begin
    repeat (watchdog_cyc_lp + 3) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run is stuck", watchdog_cyc_lp);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* project.f */
hw/clint_cfg_pkg.sv
hw/clint_bus_pkg.sv
hw/clint_apb_decode.sv
hw/clint_rtc_strobe.sv
hw/clint_slice.sv
hw/clint_resp_collect.sv
hw/clint_top.sv
verif/clint_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the clint testbench with verilator, run it, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module clint_tb -o clint_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/clint_sim > sim.log 2>&1 ; cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
  || grep -q "TB PASSED" sim.log \
  || { echo "simulation ended without a verdict"; exit 1; }
exit 0
